// File: src/ss_pkg.sv
package ss_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // why a record carries no real instruction
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_PIPE  = 2'd1,
        STALL_RESET = 2'd2
    } stall_code_t;

    // opcode field is insn[15:12]
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_CONST = 4'b1001;

    localparam int RD_MSB      = 11;
    localparam int RS_MSB      = 8;
    localparam int RT_MSB      = 2;
    localparam int IMM_SEL_BIT = 5;

    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
    } decoded_t;

    typedef struct packed {
        word_t       pc;
        word_t       insn;
        decoded_t    dec;
        stall_code_t stall;
    } issue_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    value;
    } fwd_t;

    typedef struct packed {
        word_t       pc;
        word_t       insn;
        logic        we;
        reg_idx_t    wsel;
        word_t       data;
        stall_code_t stall;
    } retire_t;

endpackage

// File: src/ss_decoder.sv
`timescale 1ns/1ps

module ss_decoder (
    input  ss_pkg::word_t    i_insn,
    output ss_pkg::decoded_t o_dec
);
    import ss_pkg::*;

    logic [3:0] opcode;
    logic [1:0] sub_op;
    logic       imm_sel;

    assign opcode  = i_insn[15:12];
    assign sub_op  = i_insn[4:3];
    assign imm_sel = i_insn[IMM_SEL_BIT];

    always_comb begin
        o_dec       = '0;
        o_dec.rs    = i_insn[RS_MSB -: REG_IDX_W];
        o_dec.rt    = i_insn[RT_MSB -: REG_IDX_W];
        o_dec.rd    = i_insn[RD_MSB -: REG_IDX_W];
        case (opcode)
            OP_ARITH: begin
                // DIV (sub 11) is not supported and decodes as a no-op
                if (imm_sel || sub_op != 2'b11) begin
                    o_dec.rs_re = 1'b1;
                    o_dec.rt_re = ~imm_sel;
                    o_dec.rd_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                o_dec.rs_re = 1'b1;
                // NOT and AND-immediate have no second register
                o_dec.rt_re = ~imm_sel && (sub_op != 2'b01);
                o_dec.rd_we = 1'b1;
            end
            OP_CONST: begin
                o_dec.rd_we = 1'b1;
            end
            default: begin
                o_dec.rd_we = 1'b0;
            end
        endcase
    end

endmodule

// File: src/ss_alu.sv
`timescale 1ns/1ps

module ss_alu (
    input  ss_pkg::word_t i_insn,
    input  ss_pkg::word_t i_rs_val,
    input  ss_pkg::word_t i_rt_val,
    output ss_pkg::word_t o_result
);
    import ss_pkg::*;

    word_t imm5;
    word_t imm9;

    assign imm5 = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm9 = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        o_result = '0;
        case (i_insn[15:12])
            OP_ARITH: begin
                if (i_insn[IMM_SEL_BIT]) begin
                    o_result = i_rs_val + imm5;
                end else begin
                    case (i_insn[4:3])
                        2'b00: o_result = i_rs_val + i_rt_val;
                        // only the low half of the product is kept
                        2'b01: o_result = i_rs_val * i_rt_val;
                        2'b10: o_result = i_rs_val - i_rt_val;
                        default: o_result = '0;
                    endcase
                end
            end
            OP_LOGIC: begin
                if (i_insn[IMM_SEL_BIT]) begin
                    o_result = i_rs_val & imm5;
                end else begin
                    case (i_insn[4:3])
                        2'b00: o_result = i_rs_val & i_rt_val;
                        2'b01: o_result = ~i_rs_val;
                        2'b10: o_result = i_rs_val | i_rt_val;
                        default: o_result = i_rs_val ^ i_rt_val;
                    endcase
                end
            end
            OP_CONST: o_result = imm9;
            default: o_result = '0;
        endcase
    end

endmodule

// File: src/ss_fetch_issue.sv
`timescale 1ns/1ps

module ss_fetch_issue #(
    parameter ss_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic           gwe,
    input  logic           i_rst,
    input  ss_pkg::word_t  i_insn_a,
    input  ss_pkg::word_t  i_insn_b,
    output ss_pkg::word_t  o_cur_pc,
    output ss_pkg::issue_t o_issue_a,
    output ss_pkg::issue_t o_issue_b
);
    import ss_pkg::*;

    word_t       pc_q;
    word_t       d_pc_a;
    word_t       d_pc_b;
    word_t       d_insn_a;
    word_t       d_insn_b;
    stall_code_t d_stall_a;
    stall_code_t d_stall_b;
    decoded_t    dec_a;
    decoded_t    dec_b;
    logic        b_needs_a;

    ss_decoder u_dec_a (
        .i_insn (d_insn_a),
        .o_dec  (dec_a)
    );

    ss_decoder u_dec_b (
        .i_insn (d_insn_b),
        .o_dec  (dec_b)
    );

    // B reads what A writes in the same pair
    assign b_needs_a = dec_a.rd_we &&
                       ((dec_b.rs_re && dec_b.rs == dec_a.rd) ||
                        (dec_b.rt_re && dec_b.rt == dec_a.rd));

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q      <= RESET_PC;
            d_pc_a    <= '0;
            d_pc_b    <= '0;
            d_insn_a  <= '0;
            d_insn_b  <= '0;
            d_stall_a <= STALL_RESET;
            d_stall_b <= STALL_RESET;
        end else if (b_needs_a) begin
            // pipe switch, the held B moves up into the A slot
            pc_q      <= pc_q + 16'd1;
            d_pc_a    <= d_pc_b;
            d_insn_a  <= d_insn_b;
            d_stall_a <= d_stall_b;
            d_pc_b    <= pc_q;
            d_insn_b  <= i_insn_a;
            d_stall_b <= STALL_NONE;
        end else begin
            pc_q      <= pc_q + 16'd2;
            d_pc_a    <= pc_q;
            d_insn_a  <= i_insn_a;
            d_stall_a <= STALL_NONE;
            d_pc_b    <= pc_q + 16'd1;
            d_insn_b  <= i_insn_b;
            d_stall_b <= STALL_NONE;
        end
    end

    assign o_cur_pc  = pc_q;
    assign o_issue_a = issue_t'{pc: d_pc_a, insn: d_insn_a, dec: dec_a, stall: d_stall_a};
    assign o_issue_b = b_needs_a ?
                       issue_t'{pc: d_pc_b, insn: '0, dec: '0, stall: STALL_PIPE} :
                       issue_t'{pc: d_pc_b, insn: d_insn_b, dec: dec_b, stall: d_stall_b};

endmodule

// File: src/ss_regfile.sv
`timescale 1ns/1ps

module ss_regfile (
    input  logic            gwe,
    input  logic            i_rst,
    input  ss_pkg::reg_idx_t i_rs_a,
    input  ss_pkg::reg_idx_t i_rt_a,
    input  ss_pkg::reg_idx_t i_rs_b,
    input  ss_pkg::reg_idx_t i_rt_b,
    output ss_pkg::word_t   o_rs_a,
    output ss_pkg::word_t   o_rt_a,
    output ss_pkg::word_t   o_rs_b,
    output ss_pkg::word_t   o_rt_b,
    input  ss_pkg::retire_t i_wr_a,
    input  ss_pkg::retire_t i_wr_b
);
    import ss_pkg::*;

    word_t regs [NUM_REGS];

    // same-cycle writes pass straight through, the younger B first
    function automatic word_t read_port(reg_idx_t sel, retire_t wa, retire_t wb, word_t stored);
        if (wb.we && wb.wsel == sel) begin
            return wb.data;
        end
        if (wa.we && wa.wsel == sel) begin
            return wa.data;
        end
        return stored;
    endfunction

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.we) begin
                regs[i_wr_a.wsel] <= i_wr_a.data;
            end
            // issued last so B overrides A on the same register
            if (i_wr_b.we) begin
                regs[i_wr_b.wsel] <= i_wr_b.data;
            end
        end
    end

    assign o_rs_a = read_port(i_rs_a, i_wr_a, i_wr_b, regs[i_rs_a]);
    assign o_rt_a = read_port(i_rt_a, i_wr_a, i_wr_b, regs[i_rt_a]);
    assign o_rs_b = read_port(i_rs_b, i_wr_a, i_wr_b, regs[i_rs_b]);
    assign o_rt_b = read_port(i_rt_b, i_wr_a, i_wr_b, regs[i_rt_b]);

endmodule

// File: src/ss_lane.sv
`timescale 1ns/1ps

module ss_lane (
    input  logic            gwe,
    input  logic            i_rst,
    input  ss_pkg::issue_t  i_issue,
    input  ss_pkg::word_t   i_rs_val,
    input  ss_pkg::word_t   i_rt_val,
    input  ss_pkg::fwd_t    i_m_fwd_a,
    input  ss_pkg::fwd_t    i_m_fwd_b,
    input  ss_pkg::fwd_t    i_w_fwd_a,
    input  ss_pkg::fwd_t    i_w_fwd_b,
    output ss_pkg::fwd_t    o_m_fwd,
    output ss_pkg::fwd_t    o_w_fwd,
    output ss_pkg::retire_t o_retire
);
    import ss_pkg::*;

    localparam retire_t IDLE_REC = '{
        pc: '0, insn: '0, we: 1'b0, wsel: '0, data: '0, stall: STALL_RESET
    };

    issue_t  x_issue;
    word_t   x_rs_q;
    word_t   x_rt_q;
    word_t   rs_op;
    word_t   rt_op;
    word_t   alu_result;
    retire_t x_rec;
    retire_t m_rec;
    retire_t w_rec;

    function automatic logic fwd_hit(fwd_t src, reg_idx_t sel);
        return src.we && (src.rd == sel);
    endfunction

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            x_issue <= '{pc: '0, insn: '0, dec: '0, stall: STALL_RESET};
            m_rec   <= IDLE_REC;
            w_rec   <= IDLE_REC;
        end else begin
            x_issue <= i_issue;
            m_rec   <= x_rec;
            w_rec   <= m_rec;
        end
    end

    // operand values from the register file
    always_ff @(posedge gwe) begin
        x_rs_q <= i_rs_val;
        x_rt_q <= i_rt_val;
    end

    // youngest producer wins: M of B, M of A, W of B, W of A
    assign rs_op = fwd_hit(i_m_fwd_b, x_issue.dec.rs) ? i_m_fwd_b.value :
                   fwd_hit(i_m_fwd_a, x_issue.dec.rs) ? i_m_fwd_a.value :
                   fwd_hit(i_w_fwd_b, x_issue.dec.rs) ? i_w_fwd_b.value :
                   fwd_hit(i_w_fwd_a, x_issue.dec.rs) ? i_w_fwd_a.value :
                   x_rs_q;
    assign rt_op = fwd_hit(i_m_fwd_b, x_issue.dec.rt) ? i_m_fwd_b.value :
                   fwd_hit(i_m_fwd_a, x_issue.dec.rt) ? i_m_fwd_a.value :
                   fwd_hit(i_w_fwd_b, x_issue.dec.rt) ? i_w_fwd_b.value :
                   fwd_hit(i_w_fwd_a, x_issue.dec.rt) ? i_w_fwd_a.value :
                   x_rt_q;

    ss_alu u_alu (
        .i_insn   (x_issue.insn),
        .i_rs_val (rs_op),
        .i_rt_val (rt_op),
        .o_result (alu_result)
    );

    assign x_rec = '{
        pc:    x_issue.pc,
        insn:  x_issue.insn,
        we:    x_issue.dec.rd_we,
        wsel:  x_issue.dec.rd,
        data:  alu_result,
        stall: x_issue.stall
    };

    assign o_m_fwd  = '{we: m_rec.we, rd: m_rec.wsel, value: m_rec.data};
    assign o_w_fwd  = '{we: w_rec.we, rd: w_rec.wsel, value: w_rec.data};
    assign o_retire = w_rec;

endmodule

// File: src/ss_core.sv
`timescale 1ns/1ps

module ss_core #(
    parameter ss_pkg::word_t RESET_PC = 16'h8200
) (
    input  logic            gwe,
    input  logic            i_rst,
    input  ss_pkg::word_t   i_insn_a,
    input  ss_pkg::word_t   i_insn_b,
    output ss_pkg::word_t   o_cur_pc,
    output ss_pkg::retire_t o_retire_a,
    output ss_pkg::retire_t o_retire_b
);
    import ss_pkg::*;

    issue_t issue_a;
    issue_t issue_b;
    word_t  rs_val_a;
    word_t  rt_val_a;
    word_t  rs_val_b;
    word_t  rt_val_b;
    fwd_t   m_fwd_a;
    fwd_t   m_fwd_b;
    fwd_t   w_fwd_a;
    fwd_t   w_fwd_b;

    ss_fetch_issue #(.RESET_PC(RESET_PC)) u_fetch (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_insn_a  (i_insn_a),
        .i_insn_b  (i_insn_b),
        .o_cur_pc  (o_cur_pc),
        .o_issue_a (issue_a),
        .o_issue_b (issue_b)
    );

    // reads are addressed from D, writes come from the W records
    ss_regfile u_regfile (
        .gwe    (gwe),
        .i_rst  (i_rst),
        .i_rs_a (issue_a.dec.rs),
        .i_rt_a (issue_a.dec.rt),
        .i_rs_b (issue_b.dec.rs),
        .i_rt_b (issue_b.dec.rt),
        .o_rs_a (rs_val_a),
        .o_rt_a (rt_val_a),
        .o_rs_b (rs_val_b),
        .o_rt_b (rt_val_b),
        .i_wr_a (o_retire_a),
        .i_wr_b (o_retire_b)
    );

    ss_lane u_lane_a (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_issue   (issue_a),
        .i_rs_val  (rs_val_a),
        .i_rt_val  (rt_val_a),
        .i_m_fwd_a (m_fwd_a),
        .i_m_fwd_b (m_fwd_b),
        .i_w_fwd_a (w_fwd_a),
        .i_w_fwd_b (w_fwd_b),
        .o_m_fwd   (m_fwd_a),
        .o_w_fwd   (w_fwd_a),
        .o_retire  (o_retire_a)
    );

    ss_lane u_lane_b (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_issue   (issue_b),
        .i_rs_val  (rs_val_b),
        .i_rt_val  (rt_val_b),
        .i_m_fwd_a (m_fwd_a),
        .i_m_fwd_b (m_fwd_b),
        .i_w_fwd_a (w_fwd_a),
        .i_w_fwd_b (w_fwd_b),
        .o_m_fwd   (m_fwd_b),
        .o_w_fwd   (w_fwd_b),
        .o_retire  (o_retire_b)
    );

endmodule

// File: verif/ss_core_asserts.sv
`timescale 1ns/1ps

module ss_core_asserts #(
    parameter ss_pkg::word_t RESET_PC = 16'h8200
) (
    input logic            gwe,
    input logic            i_rst,
    input ss_pkg::word_t   i_cur_pc,
    input ss_pkg::retire_t i_retire_a,
    input ss_pkg::retire_t i_retire_b
);
    import ss_pkg::*;

    // a bubble never writes the register file
    bubble_no_write_a: assert property (@(posedge gwe) disable iff (i_rst)
        (i_retire_a.stall != STALL_NONE) |-> !i_retire_a.we)
        else $error("lane A bubble record has its write enable set");

    bubble_no_write_b: assert property (@(posedge gwe) disable iff (i_rst)
        (i_retire_b.stall != STALL_NONE) |-> !i_retire_b.we)
        else $error("lane B bubble record has its write enable set");

    // only the B slot is ever held back
    no_pipe_stall_a: assert property (@(posedge gwe) disable iff (i_rst)
        i_retire_a.stall != STALL_PIPE)
        else $error("lane A retired a pipe switch bubble");

    pc_held_in_reset: assert property (@(posedge gwe)
        i_rst |=> (i_cur_pc == RESET_PC))
        else $error("PC left the reset address while reset was held");

endmodule

bind ss_core ss_core_asserts #(.RESET_PC(RESET_PC)) u_asserts (
    .gwe        (gwe),
    .i_rst      (i_rst),
    .i_cur_pc   (o_cur_pc),
    .i_retire_a (o_retire_a),
    .i_retire_b (o_retire_b)
);

// File: verif/ss_core_tb.sv
`timescale 1ns/1ps

module ss_core_tb;
    import ss_pkg::*;

    localparam word_t START_PC     = 16'h8200;
    localparam int    RESET_CYCLES = 8;
    localparam int    RANDOM_COUNT = 16;

    // one program word and the record it must retire with
    typedef struct packed {
        word_t    insn;
        reg_idx_t wsel;
        word_t    data;
        logic     dep;
    } prog_entry_t;

    logic    gwe;
    logic    i_rst;
    word_t   i_insn_a;
    word_t   i_insn_b;
    word_t   o_cur_pc;
    retire_t o_retire_a;
    retire_t o_retire_b;

    prog_entry_t prog [$];
    word_t       model_regs [NUM_REGS];
    integer      seed;
    int          errors;
    int          exp_idx;
    int          cycles;
    int          limit;
    int          pipe_pending;
    int          pipe_total;

    ss_core UUT (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .o_cur_pc   (o_cur_pc),
        .o_retire_a (o_retire_a),
        .o_retire_b (o_retire_b)
    );

    always #2 gwe = ~gwe;

    function automatic word_t sext5(logic [4:0] imm);
        return {{11{imm[4]}}, imm};
    endfunction

    function automatic word_t sext9(logic [8:0] imm);
        return {{7{imm[8]}}, imm};
    endfunction

    function automatic word_t rrr_word(logic [3:0] op, logic [1:0] sub, reg_idx_t rd,
                                       reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, 1'b0, sub, rt};
    endfunction

    function automatic word_t imm_word(logic [3:0] op, reg_idx_t rd, reg_idx_t rs,
                                       logic [4:0] imm);
        return {op, rd, rs, 1'b1, imm};
    endfunction

    function automatic word_t const_word(reg_idx_t rd, logic [8:0] imm);
        return {OP_CONST, rd, imm};
    endfunction

    task automatic add_entry(input word_t insn, input reg_idx_t wsel, input word_t data,
                             input logic dep);
        prog.push_back('{insn: insn, wsel: wsel, data: data, dep: dep});
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        reg_idx_t    rd;
        reg_idx_t    rs;
        word_t       word;
        word_t       data;
        // independent pairs, constants and immediates to distinct registers
        add_entry(const_word(3'd1, 9'h005), 3'd1, 16'h0005, 1'b0);
        add_entry(const_word(3'd2, 9'h1FD), 3'd2, 16'hFFFD, 1'b0);
        add_entry(const_word(3'd3, 9'h0FF), 3'd3, 16'h00FF, 1'b0);
        add_entry(const_word(3'd4, 9'h100), 3'd4, 16'hFF00, 1'b0);
        add_entry(imm_word(OP_ARITH, 3'd5, 3'd1, 5'h07), 3'd5, 16'h000C, 1'b0);
        add_entry(imm_word(OP_LOGIC, 3'd6, 3'd3, 5'h10), 3'd6, 16'h00F0, 1'b0);
        // operands one and two pairs old, from both lanes
        add_entry(rrr_word(OP_ARITH, 2'b00, 3'd7, 3'd2, 3'd4), 3'd7, 16'hFEFD, 1'b0);
        add_entry(rrr_word(OP_LOGIC, 2'b11, 3'd0, 3'd6, 3'd5), 3'd0, 16'h00FC, 1'b0);
        // two pipe switches in a row
        add_entry(const_word(3'd1, 9'h064), 3'd1, 16'h0064, 1'b0);
        add_entry(rrr_word(OP_ARITH, 2'b00, 3'd2, 3'd1, 3'd1), 3'd2, 16'h00C8, 1'b1);
        add_entry(rrr_word(OP_ARITH, 2'b10, 3'd3, 3'd2, 3'd7), 3'd3, 16'h01CB, 1'b1);
        add_entry(const_word(3'd6, 9'h001), 3'd6, 16'h0001, 1'b0);
        // both lanes write r4, lane B must win in M and in W
        add_entry(const_word(3'd4, 9'h055), 3'd4, 16'h0055, 1'b0);
        add_entry(const_word(3'd4, 9'h1FF), 3'd4, 16'hFFFF, 1'b0);
        add_entry(rrr_word(OP_ARITH, 2'b00, 3'd5, 3'd4, 3'd6), 3'd5, 16'h0000, 1'b0);
        add_entry(rrr_word(OP_ARITH, 2'b01, 3'd7, 3'd3, 3'd3), 3'd7, 16'h36F9, 1'b0);
        add_entry(rrr_word(OP_LOGIC, 2'b01, 3'd0, 3'd4, 3'd0), 3'd0, 16'h0000, 1'b0);
        add_entry(rrr_word(OP_LOGIC, 2'b00, 3'd1, 3'd7, 3'd3), 3'd1, 16'h00C9, 1'b0);
        add_entry(rrr_word(OP_ARITH, 2'b01, 3'd2, 3'd4, 3'd4), 3'd2, 16'h0001, 1'b0);
        add_entry(rrr_word(OP_ARITH, 2'b10, 3'd3, 3'd0, 3'd1), 3'd3, 16'hFF37, 1'b0);
        add_entry(imm_word(OP_ARITH, 3'd4, 3'd2, 5'h10), 3'd4, 16'hFFF1, 1'b0);
        add_entry(imm_word(OP_LOGIC, 3'd5, 3'd3, 5'h0F), 3'd5, 16'h0007, 1'b0);
        // B depends on A through rt only
        add_entry(rrr_word(OP_LOGIC, 2'b11, 3'd6, 3'd4, 3'd5), 3'd6, 16'hFFF6, 1'b0);
        add_entry(rrr_word(OP_LOGIC, 2'b10, 3'd0, 3'd5, 3'd6), 3'd0, 16'hFFF7, 1'b1);

        // register state after the fixed section
        model_regs[0] = 16'hFFF7;
        model_regs[1] = 16'h00C9;
        model_regs[2] = 16'h0001;
        model_regs[3] = 16'hFF37;
        model_regs[4] = 16'hFFF1;
        model_regs[5] = 16'h0007;
        model_regs[6] = 16'hFFF6;
        model_regs[7] = 16'h36F9;

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rnd = $random(seed);
            rd  = rnd[4:2];
            rs  = rnd[7:5];
            case (rnd[1:0])
                2'd1: begin
                    word = imm_word(OP_ARITH, rd, rs, rnd[12:8]);
                    data = model_regs[rs] + sext5(rnd[12:8]);
                end
                2'd2: begin
                    word = imm_word(OP_LOGIC, rd, rs, rnd[12:8]);
                    data = model_regs[rs] & sext5(rnd[12:8]);
                end
                default: begin
                    word = const_word(rd, rnd[16:8]);
                    data = sext9(rnd[16:8]);
                end
            endcase
            model_regs[rd] = data;
            add_entry(word, rd, data, 1'b0);
        end
    endtask

    // words at PC and PC+1, no-ops past the end of the program
    task automatic drive_fetch();
        word_t off16;
        int    offset;
        off16  = o_cur_pc - START_PC;
        offset = int'(off16);
        i_insn_a = '0;
        i_insn_b = '0;
        if (offset < prog.size()) begin
            i_insn_a = prog[offset].insn;
        end
        if (offset + 1 < prog.size()) begin
            i_insn_b = prog[offset + 1].insn;
        end
    endtask

    task automatic check_field(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reset_record(input string name, input retire_t rec);
        check_field({name, ".we"}, 16'd0, {15'd0, rec.we});
        check_field({name, ".stall"}, 16'(STALL_RESET), {14'd0, rec.stall});
    endtask

    task automatic check_record(input string name, input retire_t rec);
        prog_entry_t exp;
        word_t       exp_pc;
        if (rec.stall == STALL_PIPE) begin
            pipe_pending++;
            pipe_total++;
        end
        if (rec.stall == STALL_NONE && rec.insn != '0) begin
            if (exp_idx >= prog.size()) begin
                $display("error at %0d ns: %s retired an instruction past the end of the program",
                         $time, name);
                errors++;
            end else begin
                exp    = prog[exp_idx];
                exp_pc = START_PC + word_t'(exp_idx);
                check_field({name, ".pc"}, exp_pc, rec.pc);
                check_field({name, ".insn"}, exp.insn, rec.insn);
                check_field({name, ".we"}, 16'd1, {15'd0, rec.we});
                check_field({name, ".wsel"}, {13'd0, exp.wsel}, {13'd0, rec.wsel});
                check_field({name, ".data"}, exp.data, rec.data);
                if (exp.dep) begin
                    if (pipe_pending == 0) begin
                        $display("error at %0d ns: %s retired a dependent instruction %0s",
                                 $time, name, "with no pipe stall record before it");
                        errors++;
                    end
                    pipe_pending = 0;
                end
                exp_idx++;
            end
        end
    endtask

    initial begin
        gwe          = 1'b0;
        i_rst        = 1'b1;
        i_insn_a     = '0;
        i_insn_b     = '0;
        seed         = 32'hacb6_fee8;
        errors       = 0;
        exp_idx      = 0;
        cycles       = 0;
        pipe_pending = 0;
        pipe_total   = 0;
        build_program();
        limit = 4 * prog.size() + 40;

        repeat (RESET_CYCLES) begin
            @(posedge gwe);
            #1;
            check_field("o_cur_pc", START_PC, o_cur_pc);
            check_reset_record("retire_a", o_retire_a);
            check_reset_record("retire_b", o_retire_b);
            drive_fetch();
        end
        i_rst = 1'b0;

        while (exp_idx < prog.size() && cycles < limit) begin
            @(posedge gwe);
            #1;
            cycles++;
            // reset bubbles still drain out of X, M and W
            if (cycles <= 3) begin
                check_reset_record("retire_a", o_retire_a);
                check_reset_record("retire_b", o_retire_b);
            end
            check_record("retire_a", o_retire_a);
            check_record("retire_b", o_retire_b);
            drive_fetch();
        end

        if (exp_idx < prog.size()) begin
            $display("timeout: the retirements did not finish, %0d of %0d retired in %0d cycles",
                     exp_idx, prog.size(), limit);
            errors++;
        end
        $display("retired %0d of %0d, pipe stalls %0d, errors %0d",
                 exp_idx, prog.size(), pipe_total, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/ss_pkg.sv
src/ss_decoder.sv
src/ss_alu.sv
src/ss_fetch_issue.sv
src/ss_regfile.sv
src/ss_lane.sv
src/ss_core.sv
verif/ss_core_asserts.sv
verif/ss_core_tb.sv

// File: Makefile
# Verilator build and run for the two-wide LC4 pipeline

VERILATOR ?= verilator
TOP       ?= ss_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
